//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_arcade_mem_sys
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- arcade_asserts.sv
`timescale 1ns/1ps

module arcade_asserts import arcade_pkg::*; (
	input logic      CLOCK_48,
	input logic      rst_n,
	input mem_addr_t ld_paddr,
	input logic      ld_psel,
	input logic      ld_pready,
	input mem_addr_t cpu_paddr,
	input logic      cpu_psel,
	input logic      cpu_pready,
	input mem_addr_t gfx_paddr,
	input logic      gfx_psel,
	input logic      gfx_pready
);

	// One peer served at a time.
	a_one_ready: assert property (@(posedge CLOCK_48) disable iff (!rst_n)
		$onehot0({ld_pready, cpu_pready, gfx_pready}))
		else $error("more than one pready high");

	a_ready_sel: assert property (@(posedge CLOCK_48) disable iff (!rst_n)
		!(ld_pready && !ld_psel) && !(cpu_pready && !cpu_psel)
		&& !(gfx_pready && !gfx_psel))
		else $error("pready without psel");

	a_ld_sel_hold: assert property (@(posedge CLOCK_48) disable iff (!rst_n)
		(ld_psel && !ld_pready) |=> ld_psel)
		else $error("loader psel dropped before pready");

	a_cpu_sel_hold: assert property (@(posedge CLOCK_48) disable iff (!rst_n)
		(cpu_psel && !cpu_pready) |=> cpu_psel)
		else $error("cpu psel dropped before pready");

	a_gfx_sel_hold: assert property (@(posedge CLOCK_48) disable iff (!rst_n)
		(gfx_psel && !gfx_pready) |=> gfx_psel)
		else $error("gfx psel dropped before pready");

	a_ld_addr_hold: assert property (@(posedge CLOCK_48) disable iff (!rst_n)
		(ld_psel && !ld_pready) |=> $stable(ld_paddr))
		else $error("loader paddr changed before pready");

	a_cpu_addr_hold: assert property (@(posedge CLOCK_48) disable iff (!rst_n)
		(cpu_psel && !cpu_pready) |=> $stable(cpu_paddr))
		else $error("cpu paddr changed before pready");

	a_gfx_addr_hold: assert property (@(posedge CLOCK_48) disable iff (!rst_n)
		(gfx_psel && !gfx_pready) |=> $stable(gfx_paddr))
		else $error("gfx paddr changed before pready");

endmodule

bind mem_arbiter arcade_asserts u_asserts (
	.CLOCK_48   (CLOCK_48),
	.rst_n      (rst_n),
	.ld_paddr   (ld_paddr),
	.ld_psel    (ld_psel),
	.ld_pready  (ld_pready),
	.cpu_paddr  (cpu_paddr),
	.cpu_psel   (cpu_psel),
	.cpu_pready (cpu_pready),
	.gfx_paddr  (gfx_paddr),
	.gfx_psel   (gfx_psel),
	.gfx_pready (gfx_pready)
);

//--- arcade_mem_sys.sv
`timescale 1ns/1ps

module arcade_mem_sys import arcade_pkg::*; (
	input  logic        CLOCK_48,
	input  logic        rst_n,
	input  logic        ioctl_download,
	input  logic        ioctl_wr,
	input  logic [15:0] ioctl_addr,
	input  logic [7:0]  ioctl_dout,
	input  logic        reset_req,
	input  logic        cpu_req,
	input  logic [12:0] cpu_addr,
	output logic        cpu_busy,
	output logic        cpu_valid,
	output rom_word_t   cpu_data,
	input  logic        gfx_req,
	input  logic [11:0] gfx_addr,
	output logic        gfx_busy,
	output logic        gfx_valid,
	output gfx_word_t   gfx_data,
	output logic        pal_wr,
	output logic [4:0]  pal_addr,
	output logic [7:0]  pal_data,
	output logic        core_reset,
	input  hw_type_t    hwtype,
	input  logic        p1_up,
	input  logic        p1_down,
	input  logic        p1_left,
	input  logic        p1_right,
	input  logic        p1_fire_a,
	input  logic        p1_fire_b,
	input  logic        p2_up,
	input  logic        p2_down,
	input  logic        p2_left,
	input  logic        p2_right,
	input  logic        p2_fire_a,
	input  logic        p2_fire_b,
	input  logic        coin,
	input  logic        start1,
	input  logic        start2,
	input  logic        service,
	output ctr_t        ctr1,
	output ctr_t        ctr2,
	output ctr_t        ctr3
);

	mem_addr_t  ld_paddr;
	logic       ld_psel;
	logic       ld_penable;
	logic       ld_pwrite;
	rom_word_t  ld_pwdata;
	logic [1:0] ld_pstrb;
	logic       ld_pready;

	mem_addr_t  cpu_paddr;
	logic       cpu_psel;
	logic       cpu_penable;
	rom_word_t  cpu_prdata;
	logic       cpu_pready;

	mem_addr_t  gfx_paddr;
	logic       gfx_psel;
	logic       gfx_penable;
	rom_word_t  gfx_prdata;
	logic       gfx_pready;

	mem_addr_t  ram_addr;
	logic       ram_we;
	logic [1:0] ram_strb;
	rom_word_t  ram_wdata;
	rom_word_t  ram_rdata;

	mem_addr_t  cpu_start;
	mem_addr_t  gfx_start;

	// CPU code sits in the upper half, graphics pairs in the lower half.
	assign cpu_start = {1'b1, cpu_addr};
	assign gfx_start = {1'b0, gfx_addr, 1'b0};

	rom_loader u_loader (
		.CLOCK_48       (CLOCK_48),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.reset_req      (reset_req),
		.paddr          (ld_paddr),
		.psel           (ld_psel),
		.penable        (ld_penable),
		.pwrite         (ld_pwrite),
		.pwdata         (ld_pwdata),
		.pstrb          (ld_pstrb),
		.pready         (ld_pready),
		.pal_wr         (pal_wr),
		.pal_addr       (pal_addr),
		.pal_data       (pal_data),
		.core_reset     (core_reset)
	);

	rom_fetch #(.WORDS(CPU_WORDS)) u_cpu_fetch (
		.CLOCK_48    (CLOCK_48),
		.rst_n       (rst_n),
		.fetch_req   (cpu_req),
		.fetch_addr  (cpu_start),
		.fetch_busy  (cpu_busy),
		.fetch_valid (cpu_valid),
		.fetch_data  (cpu_data),
		.paddr       (cpu_paddr),
		.psel        (cpu_psel),
		.penable     (cpu_penable),
		.prdata      (cpu_prdata),
		.pready      (cpu_pready)
	);

	rom_fetch #(.WORDS(GFX_WORDS)) u_gfx_fetch (
		.CLOCK_48    (CLOCK_48),
		.rst_n       (rst_n),
		.fetch_req   (gfx_req),
		.fetch_addr  (gfx_start),
		.fetch_busy  (gfx_busy),
		.fetch_valid (gfx_valid),
		.fetch_data  (gfx_data),
		.paddr       (gfx_paddr),
		.psel        (gfx_psel),
		.penable     (gfx_penable),
		.prdata      (gfx_prdata),
		.pready      (gfx_pready)
	);

	mem_arbiter u_arbiter (
		.CLOCK_48    (CLOCK_48),
		.rst_n       (rst_n),
		.ld_paddr    (ld_paddr),
		.ld_psel     (ld_psel),
		.ld_penable  (ld_penable),
		.ld_pwrite   (ld_pwrite),
		.ld_pwdata   (ld_pwdata),
		.ld_pstrb    (ld_pstrb),
		.ld_pready   (ld_pready),
		.cpu_paddr   (cpu_paddr),
		.cpu_psel    (cpu_psel),
		.cpu_penable (cpu_penable),
		.cpu_prdata  (cpu_prdata),
		.cpu_pready  (cpu_pready),
		.gfx_paddr   (gfx_paddr),
		.gfx_psel    (gfx_psel),
		.gfx_penable (gfx_penable),
		.gfx_prdata  (gfx_prdata),
		.gfx_pready  (gfx_pready),
		.ram_addr    (ram_addr),
		.ram_we      (ram_we),
		.ram_strb    (ram_strb),
		.ram_wdata   (ram_wdata),
		.ram_rdata   (ram_rdata)
	);

	rom_ram u_ram (
		.CLOCK_48  (CLOCK_48),
		.ram_addr  (ram_addr),
		.ram_we    (ram_we),
		.ram_strb  (ram_strb),
		.ram_wdata (ram_wdata),
		.ram_rdata (ram_rdata)
	);

	input_mapper u_mapper (
		.CLOCK_48  (CLOCK_48),
		.rst_n     (rst_n),
		.hwtype    (hwtype),
		.p1_up     (p1_up),
		.p1_down   (p1_down),
		.p1_left   (p1_left),
		.p1_right  (p1_right),
		.p1_fire_a (p1_fire_a),
		.p1_fire_b (p1_fire_b),
		.p2_up     (p2_up),
		.p2_down   (p2_down),
		.p2_left   (p2_left),
		.p2_right  (p2_right),
		.p2_fire_a (p2_fire_a),
		.p2_fire_b (p2_fire_b),
		.coin      (coin),
		.start1    (start1),
		.start2    (start2),
		.service   (service),
		.ctr1      (ctr1),
		.ctr2      (ctr2),
		.ctr3      (ctr3)
	);

endmodule

//--- arcade_pkg.sv
package arcade_pkg;

	typedef logic [13:0] mem_addr_t;
	typedef logic [15:0] rom_word_t;
	typedef logic [31:0] gfx_word_t;
	typedef logic [7:0]  ctr_t;
	typedef logic [1:0]  hw_type_t;

	// Board variants that share this core.
	localparam hw_type_t HW_NINJAKUN = 2'd0;
	localparam hw_type_t HW_RAIDERS5 = 2'd1;
	localparam hw_type_t HW_NOVA2001 = 2'd2;

	// Download address bits 15:14.
	localparam logic [1:0] REGION_GFX = 2'd0;
	localparam logic [1:0] REGION_CPU = 2'd1;
	localparam logic [1:0] REGION_PAL = 2'd2;

	localparam int PAL_BYTES = 32;

	localparam int GFX_WORDS = 2;
	localparam int CPU_WORDS = 1;

	// Arbiter grant states.
	localparam logic [1:0] ARB_IDLE   = 2'd0;
	localparam logic [1:0] ARB_ACCESS = 2'd1;
	localparam logic [1:0] ARB_READY  = 2'd2;

	// Graphics bytes put address bit 13 at the bottom of the word address.
	typedef union packed {
		struct packed {
			logic [1:0]  region;
			logic [12:0] word;
			logic        lane;
		} cpu;
		struct packed {
			logic [1:0]  region;
			logic        half;
			logic [11:0] word;
			logic        lane;
		} gfx;
	} load_addr_u;

endpackage

//--- input_mapper.sv
`timescale 1ns/1ps

module input_mapper import arcade_pkg::*; (
	input  logic     CLOCK_48,
	input  logic     rst_n,
	input  hw_type_t hwtype,
	input  logic     p1_up,
	input  logic     p1_down,
	input  logic     p1_left,
	input  logic     p1_right,
	input  logic     p1_fire_a,
	input  logic     p1_fire_b,
	input  logic     p2_up,
	input  logic     p2_down,
	input  logic     p2_left,
	input  logic     p2_right,
	input  logic     p2_fire_a,
	input  logic     p2_fire_b,
	input  logic     coin,
	input  logic     start1,
	input  logic     start2,
	input  logic     service,
	output ctr_t     ctr1,
	output ctr_t     ctr2,
	output ctr_t     ctr3
);

	always_ff @(posedge CLOCK_48 or negedge rst_n) begin
		if (!rst_n) begin
			ctr1 <= 8'hff;
			ctr2 <= 8'hff;
			ctr3 <= 8'hff;
		end else begin
			case (hwtype)
				HW_RAIDERS5: begin
					ctr1 <= ~{2'b00, start1, p1_fire_a, p1_up, p1_down, p1_right, p1_left};
					ctr2 <= ~{coin, service, start2, p2_fire_a, p2_up, p2_down, p2_right,
						p2_left};
					ctr3 <= 8'hff;
				end
				HW_NOVA2001: begin
					ctr1 <= ~{p1_fire_a, p1_fire_b, 2'b00, p1_right, p1_left, p1_down, p1_up};
					ctr2 <= ~{p2_fire_a, p2_fire_b, 2'b00, p2_right, p2_left, p2_down, p2_up};
					ctr3 <= ~{5'b00000, start2, start1, coin};
				end
				default: begin
					// Ninjakun layout, coin and service bits are active high here.
					ctr1 <= ~{2'b11, start1, 1'b0, p1_fire_a, p1_fire_b, p1_right, p1_left};
					ctr2 <= ~{~coin, ~service, start2, 1'b0, p2_fire_a, p2_fire_b, p2_right,
						p2_left};
					ctr3 <= 8'hff;
				end
			endcase
		end
	end

endmodule

//--- mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import arcade_pkg::*; (
	input  logic       CLOCK_48,
	input  logic       rst_n,
	input  mem_addr_t  ld_paddr,
	input  logic       ld_psel,
	input  logic       ld_penable,
	input  logic       ld_pwrite,
	input  rom_word_t  ld_pwdata,
	input  logic [1:0] ld_pstrb,
	output logic       ld_pready,
	input  mem_addr_t  cpu_paddr,
	input  logic       cpu_psel,
	input  logic       cpu_penable,
	output rom_word_t  cpu_prdata,
	output logic       cpu_pready,
	input  mem_addr_t  gfx_paddr,
	input  logic       gfx_psel,
	input  logic       gfx_penable,
	output rom_word_t  gfx_prdata,
	output logic       gfx_pready,
	output mem_addr_t  ram_addr,
	output logic       ram_we,
	output logic [1:0] ram_strb,
	output rom_word_t  ram_wdata,
	input  rom_word_t  ram_rdata
);

	logic [1:0] state;
	// One-hot grant, bit 0 loader, bit 1 cpu, bit 2 gfx.
	logic [2:0] gnt;
	logic       in_access;
	logic       in_ready;

	assign in_access = (state == ARB_ACCESS);
	assign in_ready  = (state == ARB_READY);

	always_ff @(posedge CLOCK_48 or negedge rst_n) begin
		if (!rst_n) begin
			state <= ARB_IDLE;
			gnt   <= 3'b000;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (ld_psel) begin
						gnt   <= 3'b001;
						state <= ARB_ACCESS;
					end else if (cpu_psel) begin
						gnt   <= 3'b010;
						state <= ARB_ACCESS;
					end else if (gfx_psel) begin
						gnt   <= 3'b100;
						state <= ARB_ACCESS;
					end
				end
				ARB_ACCESS: state <= ARB_READY;
				default: begin
					state <= ARB_IDLE;
					gnt   <= 3'b000;
				end
			endcase
		end
	end

	always_comb begin
		ram_we = 1'b0;
		if (gnt[0]) begin
			ram_addr = ld_paddr;
			ram_we   = in_access & ld_pwrite;
		end else if (gnt[1]) begin
			ram_addr = cpu_paddr;
		end else begin
			ram_addr = gfx_paddr;
		end
	end

	// Only the loader writes.
	assign ram_strb  = ld_pstrb;
	assign ram_wdata = ld_pwdata;

	// Read data comes straight from the RAM output register.
	assign cpu_prdata = ram_rdata;
	assign gfx_prdata = ram_rdata;

	assign ld_pready  = in_ready & gnt[0] & ld_penable;
	assign cpu_pready = in_ready & gnt[1] & cpu_penable;
	assign gfx_pready = in_ready & gnt[2] & gfx_penable;

endmodule

//--- rom_fetch.sv
`timescale 1ns/1ps

module rom_fetch import arcade_pkg::*; #(
	parameter int WORDS = 1
) (
	input  logic                  CLOCK_48,
	input  logic                  rst_n,
	input  logic                  fetch_req,
	input  mem_addr_t             fetch_addr,
	output logic                  fetch_busy,
	output logic                  fetch_valid,
	output logic [WORDS*16-1:0]   fetch_data,
	output mem_addr_t             paddr,
	output logic                  psel,
	output logic                  penable,
	input  rom_word_t             prdata,
	input  logic                  pready
);

	logic [$clog2(WORDS + 1) - 1:0] cnt;
	logic                           beat_done;
	logic                           start;

	assign fetch_busy = psel;
	assign start      = fetch_req & ~psel;
	assign beat_done  = psel & penable & pready;

	always_ff @(posedge CLOCK_48 or negedge rst_n) begin
		if (!rst_n) begin
			psel        <= 1'b0;
			penable     <= 1'b0;
			cnt         <= '0;
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= 1'b0;
			if (start) begin
				psel    <= 1'b1;
				penable <= 1'b0;
				cnt     <= '0;
			end else if (beat_done) begin
				// Back to setup phase for the next word.
				penable <= 1'b0;
				if (cnt == WORDS - 1) begin
					psel        <= 1'b0;
					fetch_valid <= 1'b1;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end else if (psel) begin
				penable <= 1'b1;
			end
		end
	end

	// First word lands in the low half.
	always_ff @(posedge CLOCK_48) begin
		if (start)
			paddr <= fetch_addr;
		else if (beat_done)
			paddr <= paddr + 1'b1;
		if (beat_done)
			fetch_data[cnt*16 +: 16] <= prdata;
	end

endmodule

//--- rom_loader.sv
`timescale 1ns/1ps

module rom_loader import arcade_pkg::*; (
	input  logic       CLOCK_48,
	input  logic       rst_n,
	input  logic       ioctl_download,
	input  logic       ioctl_wr,
	input  logic [15:0] ioctl_addr,
	input  logic [7:0] ioctl_dout,
	input  logic       reset_req,
	output mem_addr_t  paddr,
	output logic       psel,
	output logic       penable,
	output logic       pwrite,
	output rom_word_t  pwdata,
	output logic [1:0] pstrb,
	input  logic       pready,
	output logic       pal_wr,
	output logic [4:0] pal_addr,
	output logic [7:0] pal_data,
	output logic       core_reset
);

	load_addr_u ld_addr;
	logic       wr_last;
	logic       wr_rise;
	logic       rom_hit;
	logic       pal_hit;
	logic       pal_pend;
	logic       start;
	logic       download_d;
	logic       rom_loaded;
	logic       load_done;

	assign ld_addr = ioctl_addr;
	assign wr_rise = ioctl_download & ioctl_wr & ~wr_last;
	assign rom_hit = (ld_addr.cpu.region == REGION_CPU) || (ld_addr.cpu.region == REGION_GFX);
	assign pal_hit = (ld_addr.cpu.region == REGION_PAL) && (ioctl_addr[13:0] < PAL_BYTES);
	assign start   = wr_rise & rom_hit & ~psel;

	always_ff @(posedge CLOCK_48 or negedge rst_n) begin
		if (!rst_n) begin
			wr_last  <= 1'b0;
			psel     <= 1'b0;
			penable  <= 1'b0;
			pwrite   <= 1'b0;
			pal_pend <= 1'b0;
			pal_wr   <= 1'b0;
		end else begin
			wr_last  <= ioctl_wr;
			pal_pend <= wr_rise & pal_hit;
			pal_wr   <= pal_pend;
			if (psel && penable && pready) begin
				psel    <= 1'b0;
				penable <= 1'b0;
				pwrite  <= 1'b0;
			end else if (psel) begin
				penable <= 1'b1;
			end else if (start) begin
				psel   <= 1'b1;
				pwrite <= 1'b1;
			end
		end
	end

	// Byte goes on both lanes and pstrb enables one.
	always_ff @(posedge CLOCK_48) begin
		if (start) begin
			pwdata <= {ioctl_dout, ioctl_dout};
			pstrb  <= ld_addr.cpu.lane ? 2'b10 : 2'b01;
			if (ld_addr.cpu.region == REGION_CPU)
				paddr <= {1'b1, ld_addr.cpu.word};
			else
				paddr <= {1'b0, ld_addr.gfx.word, ld_addr.gfx.half};
		end
		if (wr_rise && pal_hit) begin
			pal_addr <= ioctl_addr[4:0];
			pal_data <= ioctl_dout;
		end
	end

	assign load_done = download_d & ~ioctl_download;

	// Core stays in reset until the first download has finished.
	always_ff @(posedge CLOCK_48 or negedge rst_n) begin
		if (!rst_n) begin
			download_d <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			download_d <= ioctl_download;
			if (load_done)
				rom_loaded <= 1'b1;
			core_reset <= reset_req | ~(rom_loaded | load_done);
		end
	end

endmodule

//--- rom_ram.sv
`timescale 1ns/1ps

module rom_ram import arcade_pkg::*; (
	input  logic       CLOCK_48,
	input  mem_addr_t  ram_addr,
	input  logic       ram_we,
	input  logic [1:0] ram_strb,
	input  rom_word_t  ram_wdata,
	output rom_word_t  ram_rdata
);

	rom_word_t mem [0:(1 << $bits(mem_addr_t)) - 1];

	always_ff @(posedge CLOCK_48) begin
		if (ram_we) begin
			if (ram_strb[0])
				mem[ram_addr][7:0] <= ram_wdata[7:0];
			if (ram_strb[1])
				mem[ram_addr][15:8] <= ram_wdata[15:8];
		end
		// Old data on a same-address write.
		ram_rdata <= mem[ram_addr];
	end

endmodule

//--- tb_arcade_mem_sys.sv
`timescale 1ns/1ps

module tb_arcade_mem_sys import arcade_pkg::*; ();

	localparam int WAIT_LIMIT = 200;

	logic        CLOCK_48;
	logic        rst_n;
	logic        ioctl_download;
	logic        ioctl_wr;
	logic [15:0] ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic        reset_req;
	logic        cpu_req;
	logic [12:0] cpu_addr;
	logic        cpu_busy;
	logic        cpu_valid;
	rom_word_t   cpu_data;
	logic        gfx_req;
	logic [11:0] gfx_addr;
	logic        gfx_busy;
	logic        gfx_valid;
	gfx_word_t   gfx_data;
	logic        pal_wr;
	logic [4:0]  pal_addr;
	logic [7:0]  pal_data;
	logic        core_reset;
	hw_type_t    hwtype;
	// One bit per mapper port.
	logic [15:0] pads;
	ctr_t        ctr1;
	ctr_t        ctr2;
	ctr_t        ctr3;

	logic [31:0] lfsr = 32'h9221_aa88;
	// Byte model indexed by {word address, lane}.
	logic [7:0]  model [0:32767];
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	string       cur_test;

	arcade_mem_sys UUT (
		.CLOCK_48       (CLOCK_48),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.reset_req      (reset_req),
		.cpu_req        (cpu_req),
		.cpu_addr       (cpu_addr),
		.cpu_busy       (cpu_busy),
		.cpu_valid      (cpu_valid),
		.cpu_data       (cpu_data),
		.gfx_req        (gfx_req),
		.gfx_addr       (gfx_addr),
		.gfx_busy       (gfx_busy),
		.gfx_valid      (gfx_valid),
		.gfx_data       (gfx_data),
		.pal_wr         (pal_wr),
		.pal_addr       (pal_addr),
		.pal_data       (pal_data),
		.core_reset     (core_reset),
		.hwtype         (hwtype),
		.p1_up          (pads[0]),
		.p1_down        (pads[1]),
		.p1_left        (pads[2]),
		.p1_right       (pads[3]),
		.p1_fire_a      (pads[4]),
		.p1_fire_b      (pads[5]),
		.p2_up          (pads[6]),
		.p2_down        (pads[7]),
		.p2_left        (pads[8]),
		.p2_right       (pads[9]),
		.p2_fire_a      (pads[10]),
		.p2_fire_b      (pads[11]),
		.coin           (pads[12]),
		.start1         (pads[13]),
		.start2         (pads[14]),
		.service        (pads[15]),
		.ctr1           (ctr1),
		.ctr2           (ctr2),
		.ctr3           (ctr3)
	);

	always #50 CLOCK_48 = ~CLOCK_48;

	// Taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic next_byte(output logic [7:0] b);
		int i;
		b = 8'h00;
		for (i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic model_store(input logic [15:0] addr, input logic [7:0] data);
		load_addr_u la;
		la = addr;
		if (la.cpu.region == REGION_CPU)
			model[{1'b1, la.cpu.word, la.cpu.lane}] = data;
		else if (la.gfx.region == REGION_GFX)
			model[{1'b0, la.gfx.word, la.gfx.half, la.gfx.lane}] = data;
	endtask

	function automatic rom_word_t model_word(input mem_addr_t a);
		return {model[{a, 1'b1}], model[{a, 1'b0}]};
	endfunction

	function automatic gfx_word_t gfx_expect(input logic [11:0] g);
		return {model_word({1'b0, g, 1'b1}), model_word({1'b0, g, 1'b0})};
	endfunction

	// Active-high layout first, inverted on return.
	function automatic ctr_t expect_ctr(input hw_type_t hw, input int idx, input logic [15:0] p);
		ctr_t v;
		v = 8'h00;
		case (hw)
			HW_RAIDERS5: begin
				if (idx == 1)
					v = {2'b00, p[13], p[4], p[0], p[1], p[3], p[2]};
				else if (idx == 2)
					v = {p[12], p[15], p[14], p[10], p[6], p[7], p[9], p[8]};
			end
			HW_NOVA2001: begin
				if (idx == 1)
					v = {p[4], p[5], 2'b00, p[3], p[2], p[1], p[0]};
				else if (idx == 2)
					v = {p[10], p[11], 2'b00, p[9], p[8], p[7], p[6]};
				else
					v = {5'b00000, p[14], p[13], p[12]};
			end
			default: begin
				if (idx == 1)
					v = {2'b11, p[13], 1'b0, p[4], p[5], p[3], p[2]};
				else if (idx == 2)
					v = {~p[12], ~p[15], p[14], 1'b0, p[10], p[11], p[9], p[8]};
			end
		endcase
		return ~v;
	endfunction

	task automatic check_word(input string name, input rom_word_t exp, input rom_word_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s / %s: expected %h, actual %h", cur_test, name, exp, act);
		end
	endtask

	task automatic check_gfx(input string name, input gfx_word_t exp, input gfx_word_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s / %s: expected %h, actual %h", cur_test, name, exp, act);
		end
	endtask

	task automatic check_ctr(input string name, input ctr_t exp, input ctr_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s / %s: expected %h, actual %h", cur_test, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s / %s: expected %b, actual %b", cur_test, name, exp, act);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("Timeout: %s within %0d cycles", what, WAIT_LIMIT);
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests++;
		$display("%s: %0d errors", name, errors - errs_before);
	endtask

	task automatic wait_core_reset(input logic level, input string what);
		int n;
		n = 0;
		while (core_reset !== level && n < WAIT_LIMIT) begin
			@(negedge CLOCK_48);
			n++;
		end
		if (core_reset !== level)
			report_timeout(what);
	endtask

	// One download strobe, watching for a palette pulse on the way.
	task automatic write_byte(input logic [15:0] addr, input logic [7:0] data,
		output int pulses, output logic [4:0] seen_addr, output logic [7:0] seen_data);
		int i;
		pulses = 0;
		seen_addr = 5'd0;
		seen_data = 8'd0;
		@(posedge CLOCK_48);
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr   <= 1'b1;
		for (i = 0; i < 10; i++) begin
			@(negedge CLOCK_48);
			if (pal_wr) begin
				pulses++;
				seen_addr = pal_addr;
				seen_data = pal_data;
			end
			@(posedge CLOCK_48);
			if (i == 2)
				ioctl_wr <= 1'b0;
		end
	endtask

	task automatic run_fetch(input logic do_cpu, input logic do_gfx, input logic [12:0] caddr,
		input logic [11:0] gaddr, output rom_word_t cdata, output gfx_word_t gdata);
		int  n;
		logic cpu_done;
		logic gfx_done;
		n = 0;
		cdata = 'x;
		gdata = 'x;
		@(negedge CLOCK_48);
		while ((cpu_busy || gfx_busy) && n < WAIT_LIMIT) begin
			@(negedge CLOCK_48);
			n++;
		end
		if (cpu_busy || gfx_busy)
			report_timeout("fetch ports did not go idle");
		@(posedge CLOCK_48);
		cpu_req  <= do_cpu;
		gfx_req  <= do_gfx;
		cpu_addr <= caddr;
		gfx_addr <= gaddr;
		@(posedge CLOCK_48);
		cpu_req <= 1'b0;
		gfx_req <= 1'b0;
		@(negedge CLOCK_48);
		check_bit("cpu_busy after request", do_cpu, cpu_busy);
		check_bit("gfx_busy after request", do_gfx, gfx_busy);
		cpu_done = !do_cpu;
		gfx_done = !do_gfx;
		n = 0;
		while (!(cpu_done && gfx_done) && n < WAIT_LIMIT) begin
			@(negedge CLOCK_48);
			n++;
			if (cpu_valid && !cpu_done) begin
				cdata = cpu_data;
				cpu_done = 1'b1;
			end
			if (gfx_valid && !gfx_done) begin
				gdata = gfx_data;
				gfx_done = 1'b1;
			end
		end
		if (!(cpu_done && gfx_done))
			report_timeout("fetch data did not return");
	endtask

	task automatic test_reset();
		int e0;
		cur_test = "reset values";
		e0 = errors;
		@(negedge CLOCK_48);
		check_bit("reset core_reset", 1'b1, core_reset);
		check_ctr("reset ctr1", 8'hff, ctr1);
		check_ctr("reset ctr2", 8'hff, ctr2);
		check_ctr("reset ctr3", 8'hff, ctr3);
		check_bit("reset cpu_valid", 1'b0, cpu_valid);
		check_bit("reset gfx_valid", 1'b0, gfx_valid);
		check_bit("reset pal_wr", 1'b0, pal_wr);
		finish_test(cur_test, e0);
	endtask

	task automatic test_download();
		int          e0;
		int          i;
		int          pulses;
		logic [15:0] addr;
		logic [7:0]  b;
		logic [4:0]  pa;
		logic [7:0]  pd;
		cur_test = "download";
		e0 = errors;
		@(posedge CLOCK_48);
		ioctl_download <= 1'b1;
		for (i = 0; i < 64; i++) begin
			addr = 16'h4000 + 16'(i);
			next_byte(b);
			write_byte(addr, b, pulses, pa, pd);
			check_bit($sformatf("no pal_wr for %h", addr), 1'b1, pulses == 0);
			model_store(addr, b);
		end
		@(negedge CLOCK_48);
		check_bit("core_reset during cpu load", 1'b1, core_reset);
		// Half 0 then half 1 of graphics words 0 to 15.
		for (i = 0; i < 64; i++) begin
			addr = (i < 32) ? 16'(i) : 16'h2000 + 16'(i - 32);
			next_byte(b);
			write_byte(addr, b, pulses, pa, pd);
			check_bit($sformatf("no pal_wr for %h", addr), 1'b1, pulses == 0);
			model_store(addr, b);
		end
		@(negedge CLOCK_48);
		check_bit("core_reset during gfx load", 1'b1, core_reset);
		@(posedge CLOCK_48);
		ioctl_download <= 1'b0;
		@(negedge CLOCK_48);
		check_bit("core_reset as download ends", 1'b1, core_reset);
		wait_core_reset(1'b0, "core_reset to fall after the download");
		check_bit("core_reset after download", 1'b0, core_reset);
		// Once loaded, core reset tracks reset_req.
		@(posedge CLOCK_48);
		reset_req <= 1'b1;
		@(negedge CLOCK_48);
		wait_core_reset(1'b1, "core_reset to follow reset_req high");
		check_bit("core_reset with reset_req high", 1'b1, core_reset);
		@(posedge CLOCK_48);
		reset_req <= 1'b0;
		@(negedge CLOCK_48);
		wait_core_reset(1'b0, "core_reset to follow reset_req low");
		check_bit("core_reset with reset_req low", 1'b0, core_reset);
		finish_test(cur_test, e0);
	endtask

	task automatic test_cpu_reads();
		int        e0;
		int        w;
		rom_word_t cw;
		gfx_word_t gw;
		cur_test = "cpu reads";
		e0 = errors;
		for (w = 0; w < 32; w++) begin
			run_fetch(1'b1, 1'b0, 13'(w), 12'd0, cw, gw);
			check_word($sformatf("cpu word %0d", w), model_word({1'b1, 13'(w)}), cw);
		end
		finish_test(cur_test, e0);
	endtask

	task automatic test_gfx_reads();
		int        e0;
		int        k;
		logic [7:0] b;
		logic [7:0] b2;
		rom_word_t cw;
		gfx_word_t gw;
		cur_test = "gfx reads and contention";
		e0 = errors;
		for (k = 0; k < 16; k++) begin
			run_fetch(1'b0, 1'b1, 13'd0, 12'(k), cw, gw);
			check_gfx($sformatf("gfx word %0d", k), gfx_expect(12'(k)), gw);
		end
		// Both ports requested in the same cycle.
		for (k = 0; k < 8; k++) begin
			next_byte(b);
			next_byte(b2);
			run_fetch(1'b1, 1'b1, {8'd0, b[4:0]}, {8'd0, b2[3:0]}, cw, gw);
			check_word($sformatf("contended cpu %0d", b[4:0]),
				model_word({1'b1, 8'd0, b[4:0]}), cw);
			check_gfx($sformatf("contended gfx %0d", b2[3:0]),
				gfx_expect({8'd0, b2[3:0]}), gw);
		end
		finish_test(cur_test, e0);
	endtask

	task automatic test_palette();
		int         e0;
		int         i;
		int         pulses;
		logic [7:0] b;
		logic [4:0] pa;
		logic [7:0] pd;
		rom_word_t  cw;
		gfx_word_t  gw;
		cur_test = "palette";
		e0 = errors;
		@(posedge CLOCK_48);
		ioctl_download <= 1'b1;
		for (i = 0; i < PAL_BYTES; i++) begin
			next_byte(b);
			write_byte(16'h8000 + 16'(i), b, pulses, pa, pd);
			check_bit($sformatf("pal_wr single pulse %0d", i), 1'b1, pulses == 1);
			check_word($sformatf("palette entry %0d", i), {3'b000, 5'(i), b},
				{3'b000, pa, pd});
		end
		@(negedge CLOCK_48);
		check_bit("core_reset during palette", 1'b0, core_reset);
		@(posedge CLOCK_48);
		ioctl_download <= 1'b0;
		for (i = 0; i < 4; i++) begin
			run_fetch(1'b1, 1'b0, 13'(i), 12'd0, cw, gw);
			check_word($sformatf("cpu word %0d after palette", i),
				model_word({1'b1, 13'(i)}), cw);
		end
		for (i = 0; i < 2; i++) begin
			run_fetch(1'b0, 1'b1, 13'd0, 12'(i), cw, gw);
			check_gfx($sformatf("gfx word %0d after palette", i), gfx_expect(12'(i)), gw);
		end
		finish_test(cur_test, e0);
	endtask

	task automatic test_mapper();
		int          e0;
		int          k;
		int          p;
		hw_type_t    hw;
		logic [15:0] pat;
		logic [7:0]  lo;
		logic [7:0]  hi;
		cur_test = "input mapper";
		e0 = errors;
		for (k = 0; k < 3; k++) begin
			hw = (k == 0) ? HW_NINJAKUN : (k == 1) ? HW_RAIDERS5 : HW_NOVA2001;
			for (p = 0; p < 8; p++) begin
				next_byte(lo);
				next_byte(hi);
				pat = (p == 0) ? 16'h0000 : (p == 1) ? 16'hffff : {hi, lo};
				@(posedge CLOCK_48);
				hwtype <= hw;
				pads   <= pat;
				@(posedge CLOCK_48);
				@(negedge CLOCK_48);
				check_ctr($sformatf("hw %0d pads %h ctr1", hw, pat),
					expect_ctr(hw, 1, pat), ctr1);
				check_ctr($sformatf("hw %0d pads %h ctr2", hw, pat),
					expect_ctr(hw, 2, pat), ctr2);
				check_ctr($sformatf("hw %0d pads %h ctr3", hw, pat),
					expect_ctr(hw, 3, pat), ctr3);
			end
		end
		finish_test(cur_test, e0);
	endtask

	initial begin
		CLOCK_48       = 1'b0;
		rst_n          = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = 16'h0000;
		ioctl_dout     = 8'h00;
		reset_req      = 1'b0;
		cpu_req        = 1'b0;
		cpu_addr       = 13'd0;
		gfx_req        = 1'b0;
		gfx_addr       = 12'd0;
		hwtype         = HW_NINJAKUN;
		pads           = 16'h0000;

		repeat (15) @(posedge CLOCK_48);
		test_reset();
		@(posedge CLOCK_48);
		rst_n <= 1'b1;

		test_download();
		test_cpu_reads();
		test_gfx_reads();
		test_palette();
		test_mapper();

		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- vlog.f
arcade_pkg.sv
rom_ram.sv
rom_loader.sv
rom_fetch.sv
mem_arbiter.sv
input_mapper.sv
arcade_mem_sys.sv
arcade_asserts.sv
tb_arcade_mem_sys.sv
